// File: tb.f
+incdir+common
common/decode_pkg.sv
common/dec_if.sv
design/decoder.sv
design/imm_gen.sv
design/regfile.sv
design/issue_reg.sv
design/id_stage.sv
test/id_stage_asserts.sv
test/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - common

sources:
  - files:
      - common/decode_pkg.sv
      - common/dec_if.sv
      - design/decoder.sv
      - design/imm_gen.sv
      - design/regfile.sv
      - design/issue_reg.sv
      - design/id_stage.sv
  - target: test
    files:
      - test/id_stage_asserts.sv
      - test/id_stage_tb.sv

// File: test/id_stage_tb.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module id_stage_tb
    import decode_pkg::*;
();
    typedef struct {
        instr_t     instr;
        word_t      pc;
        logic       valid;
        logic       flush;
        decode_op_t op;
        alufunc_t   fn;
        logic       rw;
        word_t      imm;
        logic       exp_valid;
        logic       wb_en;
        reg_addr_t  wb_addr;
        word_t      wb_data;
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       flush;
    instr_t     instr;
    word_t      pc;
    logic       wb_en;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       out_valid;
    decode_op_t out_op;
    alufunc_t   out_alufunc;
    logic       out_regwrite;
    reg_addr_t  out_rd;
    word_t      out_opa;
    word_t      out_opb;
    word_t      out_imm;
    word_t      out_store_data;

    entry_t     stim_q[$];
    word_t      model [0:`NUM_REGS-1];
    logic [15:0] lfsr_state;
    int         test_errs;
    int         pass_count;
    int         fail_count;
    logic       table_built;

    id_stage id_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t random_word();
        word_t w;
        for (int b = 0; b < `XLEN; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic word_t sx(input int v);
        longint l;
        l = v;
        return word_t'(l);
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd, input logic [6:0] opc);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instr_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instr_t enc_s(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3, input logic [6:0] opc);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc};
    endfunction

    function automatic instr_t enc_b(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `F7_BRANCH};
    endfunction

    function automatic instr_t enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[31:12], rd[4:0], opc};
    endfunction

    function automatic instr_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `F7_JAL};
    endfunction

    task automatic add_entry(input instr_t ins, input logic v, input logic f,
                             input decode_op_t op, input alufunc_t fn, input logic rw,
                             input word_t imm, input logic ev);
        entry_t e;
        e.instr     = ins;
        e.pc        = 64'h8000_0000 + 4 * stim_q.size();
        e.valid     = v;
        e.flush     = f;
        e.op        = op;
        e.fn        = fn;
        e.rw        = rw;
        e.imm       = imm;
        e.exp_valid = ev;
        e.wb_en     = 1'b0;
        e.wb_addr   = '0;
        e.wb_data   = '0;
        stim_q.push_back(e);
    endtask

    task automatic add_valid(input instr_t ins, input decode_op_t op, input alufunc_t fn,
                             input logic rw, input word_t imm);
        add_entry(ins, 1'b1, 1'b0, op, fn, rw, imm, 1'b1);
    endtask

    task automatic build_table();
        add_valid(enc_r(`F7_FIRST_ADD, 2, 1, 3'b000, 3, `F7_ALU), ALU, ADD, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_SUB, 4, 3, 3'b000, 5, `F7_ALU), ALU, SUB, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 6, 5, 3'b001, 7, `F7_ALU), ALU, SLL, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 8, 7, 3'b010, 9, `F7_ALU), ALU, SLT, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 10, 9, 3'b011, 11, `F7_ALU), ALU, SLTU, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 12, 11, 3'b100, 13, `F7_ALU), ALU, XOR, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 14, 13, 3'b101, 15, `F7_ALU), ALU, SRL, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_SUB, 16, 15, 3'b101, 17, `F7_ALU), ALU, SRA, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 18, 17, 3'b110, 19, `F7_ALU), ALU, OR, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 20, 19, 3'b111, 21, `F7_ALU), ALU, AND, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 22, 21, 3'b000, 23, `F7_ALUW), ALUW, ADD, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_SUB, 24, 23, 3'b000, 25, `F7_ALUW), ALUW, SUB, 1'b1, '0);
        // The M extension reuses the funct3 values of the base encodings above.
        add_valid(enc_r(`F7_FIRST_MUL, 26, 25, 3'b000, 27, `F7_ALU), ALU, MULT, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_MUL, 28, 27, 3'b100, 29, `F7_ALU), ALU, DIV, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_MUL, 30, 29, 3'b101, 31, `F7_ALU), ALU, DIVU, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_MUL, 1, 31, 3'b110, 2, `F7_ALU), ALU, REM, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_MUL, 3, 2, 3'b111, 4, `F7_ALU), ALU, REMU, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_MUL, 5, 4, 3'b000, 6, `F7_ALUW), ALUW, MULT, 1'b1, '0);
        add_valid(enc_i(12'h123, 1, 3'b000, 2, `F7_ALUI), ALUI, ADD, 1'b1, sx(12'h123));
        add_valid(enc_i(-5, 2, 3'b000, 3, `F7_ALUI), ALUI, ADD, 1'b1, sx(-5));
        add_valid(enc_i(-256, 3, 3'b100, 4, `F7_ALUI), ALUI, XOR, 1'b1, sx(-256));
        add_valid(enc_i(12'h405, 4, 3'b101, 5, `F7_ALUI), ALUI, SRA, 1'b1, sx(12'h405));
        add_valid(enc_i(-2048, 5, 3'b000, 6, `F7_ALUIW), ALUIW, ADD, 1'b1, sx(-2048));
        add_valid(enc_i(-8, 5, 3'b011, 6, `F7_LD), LD, ADD, 1'b1, sx(-8));
        add_valid(enc_s(16, 7, 8, 3'b011, `F7_SD), SD, ADD, 1'b0, sx(16));
        add_valid(enc_s(-32, 9, 10, 3'b011, `F7_SD), SD, ADD, 1'b0, sx(-32));
        add_valid(enc_u(32'h1234_5000, 11, `F7_LUI), LUI, CPYB, 1'b1, sx(32'h1234_5000));
        add_valid(enc_u(32'hFFFF_F000, 12, `F7_LUI), LUI, CPYB, 1'b1, sx(32'hFFFF_F000));
        add_valid(enc_u(32'h0000_1000, 13, `F7_AUIPC), AUIPC, ADD, 1'b1, sx(32'h1000));
        add_valid(enc_u(32'h8000_0000, 14, `F7_AUIPC), AUIPC, ADD, 1'b1, sx(32'h8000_0000));
        add_valid(enc_j(2048, 1), JAL, ADD, 1'b1, sx(2048));
        add_valid(enc_j(-4, 1), JAL, ADD, 1'b1, sx(-4));
        add_valid(enc_i(12, 15, 3'b000, 1, `F7_JALR), JALR, ADD, 1'b1, sx(12));
        add_valid(enc_b(16, 2, 1, 3'b000), BEQ, COMPARE, 1'b0, sx(16));
        add_valid(enc_b(-8, 4, 3, 3'b001), BNE, COMPARE, 1'b0, sx(-8));
        add_valid(enc_b(4094, 6, 5, 3'b100), BLT, SLT, 1'b0, sx(4094));
        add_valid(enc_b(-4096, 8, 7, 3'b101), BGE, SLT, 1'b0, sx(-4096));
        add_valid(enc_b(32, 10, 9, 3'b110), BLTU, SLTU, 1'b0, sx(32));
        add_valid(enc_b(-2, 12, 11, 3'b111), BGEU, SLTU, 1'b0, sx(-2));
        // x0 was written in the setup phase and must still read zero.
        add_valid(enc_r(`F7_FIRST_ADD, 0, 0, 3'b000, 5, `F7_ALU), ALU, ADD, 1'b1, '0);
        add_valid(enc_r(`F7_FIRST_ADD, 10, 9, 3'b000, 7, `F7_ALU), ALU, ADD, 1'b1, '0);
        stim_q[stim_q.size()-1].wb_en   = 1'b1;
        stim_q[stim_q.size()-1].wb_addr = 5'd9;
        stim_q[stim_q.size()-1].wb_data = 64'hdead_beef_0000_1234;
        add_entry(enc_r(`F7_FIRST_SUB, 2, 1, 3'b000, 3, `F7_ALU), 1'b0, 1'b0,
                  ALU, SUB, 1'b1, '0, 1'b0);
        add_entry(enc_r(`F7_FIRST_ADD, 2, 1, 3'b000, 3, `F7_ALU), 1'b1, 1'b1,
                  ALU, ADD, 1'b1, '0, 1'b0);
        add_valid(enc_i(7, 1, 3'b110, 8, `F7_ALUI), ALUI, OR, 1'b1, sx(7));
    endtask

    function automatic word_t expected_opa(input decode_op_t op, input word_t pc_v,
                                           input word_t rs1_v);
        case (op)
            AUIPC, JAL, JALR: return pc_v;
            LUI:              return '0;
            default:          return rs1_v;
        endcase
    endfunction

    function automatic word_t expected_opb(input decode_op_t op, input word_t rs2_v,
                                           input word_t imm_v);
        case (op)
            ALU, ALUW, BEQ, BNE, BLT, BGE, BLTU, BGEU: return rs2_v;
            JAL, JALR:                                 return 64'd4;
            default:                                   return imm_v;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    initial begin
        entry_t    e;
        entry_t    last;
        word_t     last_opa;
        word_t     last_opb;
        word_t     last_sd;
        word_t     opa_e;
        word_t     opb_e;
        word_t     sd_e;

        rst_n       = 1'b0;
        in_valid    = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        lfsr_state  = 16'd95;
        pass_count  = 0;
        fail_count  = 0;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_errs = 0;
        check_value("out_valid", word_t'(out_valid), '0);
        check_value("out_regwrite", word_t'(out_regwrite), '0);
        $display("test reset: %s", test_errs == 0 ? "ok" : "mismatch");
        if (test_errs == 0)
            pass_count++;
        else
            fail_count++;

        model[0] = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            wb_en   = 1'b1;
            wb_addr = reg_addr_t'(r);
            wb_data = random_word();
            if (r != 0)
                model[r] = wb_data;
            @(negedge clk);
        end
        wb_en = 1'b0;

        for (int i = 0; i < stim_q.size(); i++) begin
            e        = stim_q[i];
            instr    = e.instr;
            pc       = e.pc;
            in_valid = e.valid;
            flush    = e.flush;
            wb_en    = e.wb_en;
            wb_addr  = e.wb_addr;
            wb_data  = e.wb_data;
            // A same-cycle writeback is forwarded, so the model takes it first.
            if (e.wb_en && e.wb_addr != 0)
                model[e.wb_addr] = e.wb_data;
            opa_e = expected_opa(e.op, e.pc, model[e.instr[19:15]]);
            opb_e = expected_opb(e.op, model[e.instr[24:20]], e.imm);
            sd_e  = model[e.instr[24:20]];
            if (e.exp_valid) begin
                last     = e;
                last_opa = opa_e;
                last_opb = opb_e;
                last_sd  = sd_e;
            end
            @(negedge clk);
            test_errs = 0;
            check_value("out_valid", word_t'(out_valid), word_t'(e.exp_valid));
            check_value("out_regwrite", word_t'(out_regwrite),
                        word_t'(e.exp_valid && e.rw));
            check_value("out_op", word_t'(out_op), word_t'(last.op));
            check_value("out_alufunc", word_t'(out_alufunc), word_t'(last.fn));
            check_value("out_rd", word_t'(out_rd), word_t'(last.instr[11:7]));
            check_value("out_imm", out_imm, last.imm);
            check_value("out_opa", out_opa, last_opa);
            check_value("out_opb", out_opb, last_opb);
            check_value("out_store_data", out_store_data, last_sd);
            $display("test %0d: %s", i, test_errs == 0 ? "ok" : "mismatch");
            if (test_errs == 0)
                pass_count++;
            else
                fail_count++;
        end
        in_valid = 1'b0;
        wb_en    = 1'b0;
        @(negedge clk);

        $display("%0d tests ok, %0d tests with errors, %0d assertion failures",
                 pass_count, fail_count, id_stage_i.id_stage_asserts_i.fail_cnt);
        if (fail_count == 0 && id_stage_i.id_stage_asserts_i.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Setup covers reset, the register fill and some margin.
    initial begin
        wait (table_built);
        #((stim_q.size() * 20 + 60) * 10);
        $display("Timeout: the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end
endmodule

// File: test/id_stage_asserts.sv
`timescale 1ns/1ns

module id_stage_asserts
    import decode_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       flush,
    input logic       out_valid,
    input logic       out_regwrite,
    input decode_op_t out_op
);
    int fail_cnt = 0;

    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_cnt++;
        end

    valid_follows_input: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> out_valid == $past(in_valid && !flush)
    ) else begin
        $error("out_valid does not follow in_valid and flush");
        fail_cnt++;
    end

    no_write_on_branch_store: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && (out_op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, SD}) |-> !out_regwrite
    ) else begin
        $error("out_regwrite high for a branch or store");
        fail_cnt++;
    end
endmodule

bind id_stage id_stage_asserts id_stage_asserts_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .flush        (flush),
    .out_valid    (out_valid),
    .out_regwrite (out_regwrite),
    .out_op       (out_op)
);

// File: design/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       flush,
    input  instr_t     instr,
    input  word_t      pc,
    input  logic       wb_en,
    input  reg_addr_t  wb_addr,
    input  word_t      wb_data,
    output logic       out_valid,
    output decode_op_t out_op,
    output alufunc_t   out_alufunc,
    output logic       out_regwrite,
    output reg_addr_t  out_rd,
    output word_t      out_opa,
    output word_t      out_opb,
    output word_t      out_imm,
    output word_t      out_store_data
);
    word_t rs1_data;
    word_t rs2_data;

    dec_if dec_bus ();

    // Register indices sit at fixed positions in every format.
    assign dec_bus.rs1 = instr[19:15];
    assign dec_bus.rs2 = instr[24:20];
    assign dec_bus.rd  = instr[11:7];

    decoder decoder_i (
        .instr (instr),
        .dec   (dec_bus.dec_src)
    );

    imm_gen imm_gen_i (
        .instr (instr),
        .dec   (dec_bus.imm_src)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec_bus.rs1),
        .rs2      (dec_bus.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    issue_reg issue_reg_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .flush          (flush),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .dec            (dec_bus.sink),
        .out_valid      (out_valid),
        .out_op         (out_op),
        .out_alufunc    (out_alufunc),
        .out_regwrite   (out_regwrite),
        .out_rd         (out_rd),
        .out_opa        (out_opa),
        .out_opb        (out_opb),
        .out_imm        (out_imm),
        .out_store_data (out_store_data)
    );
endmodule

// File: design/issue_reg.sv
`timescale 1ns/1ns

module issue_reg
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       flush,
    input  word_t      pc,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    dec_if.sink        dec,
    output logic       out_valid,
    output decode_op_t out_op,
    output alufunc_t   out_alufunc,
    output logic       out_regwrite,
    output reg_addr_t  out_rd,
    output word_t      out_opa,
    output word_t      out_opb,
    output word_t      out_imm,
    output word_t      out_store_data
);
    logic  accept;
    word_t opa;
    word_t opb;

    assign accept = in_valid && !flush;

    always_comb begin
        unique case (dec.op)
            AUIPC, JAL, JALR: opa = pc;
            LUI:              opa = '0;
            default:          opa = rs1_data;
        endcase
    end

    // Jumps add 4 to pc to form the link address.
    always_comb begin
        unique case (dec.op)
            ALU, ALUW, BEQ, BNE, BLT, BGE, BLTU, BGEU: opb = rs2_data;
            JAL, JALR:                                 opb = word_t'(4);
            default:                                   opb = dec.imm;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            out_regwrite <= 1'b0;
        end else begin
            out_valid    <= accept;
            out_regwrite <= accept && dec.regwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_op         <= dec.op;
            out_alufunc    <= dec.alufunc;
            out_rd         <= dec.rd;
            out_opa        <= opa;
            out_opb        <= opb;
            out_imm        <= dec.imm;
            out_store_data <= rs2_data;
        end
    end
endmodule

// File: design/regfile.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module regfile
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data
);
    // Register x0 has no storage.
    word_t regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // A write in the same cycle is forwarded so decode sees the new value.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0)
            data = '0;
        else if (wb_en && wb_addr == addr)
            data = wb_data;
        else
            data = regs[addr];
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end
endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module imm_gen
    import decode_pkg::*;
(
    input  instr_t     instr,
    dec_if.imm_src     dec
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        unique case (instr[6:0])
            `F7_ALUI, `F7_ALUIW, `F7_JALR, `F7_LD: begin
                dec.imm = {{(`XLEN-12){sign}}, instr[31:20]};
            end
            `F7_SD: begin
                dec.imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            // B and J offsets are in halfwords, so bit 0 is always zero.
            `F7_BRANCH: begin
                dec.imm = {{(`XLEN-13){sign}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
            end
            `F7_LUI, `F7_AUIPC: begin
                dec.imm = {{(`XLEN-32){sign}}, instr[31:12], 12'b0};
            end
            `F7_JAL: begin
                dec.imm = {{(`XLEN-21){sign}}, instr[31], instr[19:12],
                           instr[20], instr[30:21], 1'b0};
            end
            default: begin
                dec.imm = '0;
            end
        endcase
    end
endmodule

// File: design/decoder.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module decoder
    import decode_pkg::*;
(
    input  instr_t     instr,
    dec_if.dec_src     dec
);
    logic [2:0] funct3;
    logic [6:0] f7_first;

    assign funct3   = instr[14:12];
    assign f7_first = instr[31:25];

    // Register-register encodings, shared by ALU and ALUW.
    // The M extension is picked out by funct7.
    function automatic alufunc_t rtype_func(input logic [2:0] f3, input logic [6:0] f7);
        alufunc_t f;
        f = ADD;
        case (f3)
            3'b000: begin
                if (f7 == `F7_FIRST_SUB)
                    f = SUB;
                else if (f7 == `F7_FIRST_MUL)
                    f = MULT;
                else
                    f = ADD;
            end
            3'b100: f = (f7 == `F7_FIRST_MUL) ? DIV : XOR;
            3'b110: f = (f7 == `F7_FIRST_MUL) ? REM : OR;
            3'b111: f = (f7 == `F7_FIRST_MUL) ? REMU : AND;
            3'b010: f = SLT;
            3'b011: f = SLTU;
            3'b001: f = SLL;
            3'b101: begin
                if (f7 == `F7_FIRST_SUB)
                    f = SRA;
                else if (f7 == `F7_FIRST_MUL)
                    f = DIVU;
                else
                    f = SRL;
            end
            default: f = ADD;
        endcase
        return f;
    endfunction

    // Register-immediate encodings, shared by ALUI and ALUIW.
    function automatic alufunc_t itype_func(input logic [2:0] f3, input logic arith);
        alufunc_t f;
        f = ADD;
        case (f3)
            3'b000: f = ADD;
            3'b100: f = XOR;
            3'b110: f = OR;
            3'b111: f = AND;
            3'b010: f = SLT;
            3'b011: f = SLTU;
            3'b001: f = SLL;
            3'b101: f = arith ? SRA : SRL;
            default: f = ADD;
        endcase
        return f;
    endfunction

    always_comb begin
        dec.op       = ALUI;
        dec.alufunc  = ADD;
        dec.regwrite = 1'b1;

        unique case (instr[6:0])
            `F7_ALUI: begin
                dec.op      = ALUI;
                dec.alufunc = itype_func(funct3, instr[30]);
            end
            `F7_ALU: begin
                dec.op      = ALU;
                dec.alufunc = rtype_func(funct3, f7_first);
            end
            `F7_ALUIW: begin
                dec.op      = ALUIW;
                dec.alufunc = itype_func(funct3, instr[30]);
            end
            `F7_ALUW: begin
                dec.op      = ALUW;
                dec.alufunc = rtype_func(funct3, f7_first);
            end
            `F7_LUI: begin
                dec.op      = LUI;
                dec.alufunc = CPYB;
            end
            `F7_JAL: begin
                dec.op = JAL;
            end
            `F7_JALR: begin
                dec.op = JALR;
            end
            `F7_BRANCH: begin
                dec.regwrite = 1'b0;
                // Equality uses COMPARE, ordering reuses the set-less-than units.
                case (funct3)
                    3'b000: begin
                        dec.op      = BEQ;
                        dec.alufunc = COMPARE;
                    end
                    3'b001: begin
                        dec.op      = BNE;
                        dec.alufunc = COMPARE;
                    end
                    3'b100: begin
                        dec.op      = BLT;
                        dec.alufunc = SLT;
                    end
                    3'b101: begin
                        dec.op      = BGE;
                        dec.alufunc = SLT;
                    end
                    3'b110: begin
                        dec.op      = BLTU;
                        dec.alufunc = SLTU;
                    end
                    3'b111: begin
                        dec.op      = BGEU;
                        dec.alufunc = SLTU;
                    end
                    default: begin
                    end
                endcase
            end
            `F7_LD: begin
                dec.op = LD;
            end
            `F7_SD: begin
                dec.op       = SD;
                dec.regwrite = 1'b0;
            end
            `F7_AUIPC: begin
                dec.op = AUIPC;
            end
            default: begin
            end
        endcase
    end
endmodule

// File: common/dec_if.sv
`timescale 1ns/1ns

interface dec_if
    import decode_pkg::*;
();
    decode_op_t op;
    alufunc_t   alufunc;
    logic       regwrite;
    word_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;

    modport dec_src (output op, output alufunc, output regwrite);

    modport imm_src (output imm);

    modport sink (
        input op, input alufunc, input regwrite, input imm,
        input rs1, input rs2, input rd
    );
endinterface

// File: common/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`INSTR_W-1:0]    instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Operation class, tells execute which unit and which operand use applies.
    typedef enum logic [4:0] {
        ALUI,
        ALU,
        ALUIW,
        ALUW,
        LUI,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LD,
        SD,
        AUIPC
    } decode_op_t;

    // CPYB passes operand b straight through, as LUI needs.
    typedef enum logic [4:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MULT,
        DIV,
        DIVU,
        REM,
        REMU,
        CPYB,
        COMPARE
    } alufunc_t;

endpackage

// File: common/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath and register file dimensions.
`define XLEN        64
`define INSTR_W     32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Major opcodes, instr[6:0].
`define F7_ALUI     7'b0010011
`define F7_ALU      7'b0110011
`define F7_ALUIW    7'b0011011
`define F7_ALUW     7'b0111011
`define F7_LUI      7'b0110111
`define F7_AUIPC    7'b0010111
`define F7_JAL      7'b1101111
`define F7_JALR     7'b1100111
`define F7_BRANCH   7'b1100011
`define F7_LD       7'b0000011
`define F7_SD       7'b0100011

// Values of funct7, instr[31:25].
`define F7_FIRST_ADD 7'b0000000
`define F7_FIRST_SUB 7'b0100000
`define F7_FIRST_MUL 7'b0000001

`endif
